// File: design/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    localparam int XLEN     = 32;
    localparam int NUM_REGS = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      reg_addr_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_LUI     // passes the shifted immediate
    } alu_op_e;

    typedef enum logic [1:0] {
        BR_NONE,
        BR_EQ,
        BR_NE,
        BR_ALWAYS
    } br_op_e;

    // register-register forms, instr[31:15]
    localparam logic [16:0] OP17_ADD  = 17'h00020;
    localparam logic [16:0] OP17_SUB  = 17'h00022;
    localparam logic [16:0] OP17_SLT  = 17'h00024;
    localparam logic [16:0] OP17_SLTU = 17'h00025;
    localparam logic [16:0] OP17_AND  = 17'h00029;
    localparam logic [16:0] OP17_OR   = 17'h0002a;
    localparam logic [16:0] OP17_XOR  = 17'h0002b;

    // instr[31:22]
    localparam logic [9:0]  OP10_ADDI = 10'h00a;

    // instr[31:25]
    localparam logic [6:0]  OP7_LU12I = 7'h0a;

    // branches, instr[31:26]
    localparam logic [5:0]  OP6_B     = 6'h14;
    localparam logic [5:0]  OP6_BEQ   = 6'h16;
    localparam logic [5:0]  OP6_BNE   = 6'h17;

endpackage

`default_nettype wire

// File: design/regfile.sv
`timescale 1ns/1ps
`default_nettype none

module regfile import cpu_pkg::*; (
    input  wire logic      clk,
    input  wire logic      i_rst_n,
    input  wire reg_addr_t i_raddr_a,
    input  wire reg_addr_t i_raddr_b,
    output      word_t     o_rdata_a,
    output      word_t     o_rdata_b,
    input  wire logic      i_we,
    input  wire reg_addr_t i_waddr,
    input  wire word_t     i_wdata
);

    word_t regs [NUM_REGS];

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && i_waddr != '0) begin
            regs[i_waddr] <= i_wdata;
        end
    end

    // r0 reads zero, same-cycle write passes through
    always_comb begin
        if (i_raddr_a == '0) begin
            o_rdata_a = '0;
        end else if (i_we && i_waddr == i_raddr_a) begin
            o_rdata_a = i_wdata;
        end else begin
            o_rdata_a = regs[i_raddr_a];
        end

        if (i_raddr_b == '0) begin
            o_rdata_b = '0;
        end else if (i_we && i_waddr == i_raddr_b) begin
            o_rdata_b = i_wdata;
        end else begin
            o_rdata_b = regs[i_raddr_b];
        end
    end

endmodule

`default_nettype wire

// File: design/fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_stage import cpu_pkg::*; #(
    parameter word_t RESET_PC = 32'h1c00_0000
) (
    input  wire logic  clk,
    input  wire logic  i_rst_n,
    input  wire logic  i_redirect,
    input  wire word_t i_redirect_pc,
    output      word_t o_imem_addr,
    output      word_t o_if_pc,
    output      logic  o_if_valid
);

    word_t pc;
    word_t pc_next;

    assign pc_next     = i_redirect ? i_redirect_pc : pc + 32'd4;
    assign o_imem_addr = pc;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            pc <= RESET_PC;
        end else begin
            pc <= pc_next;
        end
    end

    // word for pc returns one edge later, tag it here
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_if_valid <= 1'b0;
        end else begin
            o_if_valid <= ~i_redirect; // kill the word in flight
        end
    end

    always_ff @(posedge clk) begin
        o_if_pc <= pc;
    end

endmodule

`default_nettype wire

// File: design/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage import cpu_pkg::*; (
    input  wire logic      clk,
    input  wire logic      i_rst_n,
    input  wire word_t     i_instr,
    input  wire word_t     i_pc,
    input  wire logic      i_valid,
    input  wire logic      i_flush,
    output      reg_addr_t o_rj,
    output      reg_addr_t o_rk,
    input  wire word_t     i_rdata_j,
    input  wire word_t     i_rdata_k,
    output      logic      o_ex_valid,
    output      word_t     o_ex_pc,
    output      alu_op_e   o_ex_alu_op,
    output      br_op_e    o_ex_br_op,
    output      logic      o_ex_use_imm,
    output      word_t     o_ex_imm,
    output      reg_addr_t o_ex_rj,
    output      reg_addr_t o_ex_rk,
    output      reg_addr_t o_ex_rd,
    output      logic      o_ex_we,
    output      word_t     o_ex_br_target,
    output      word_t     o_ex_rdata_j,
    output      word_t     o_ex_rdata_k
);

    reg_addr_t rd;
    alu_op_e   rr_op;
    logic      rr_hit;
    alu_op_e   alu_op;
    br_op_e    br_op;
    logic      use_imm;
    logic      we_raw;
    word_t     imm;
    word_t     br_offs;

    assign rd   = i_instr[4:0];
    assign o_rj = i_instr[9:5];
    // beq/bne compare rj against rd
    assign o_rk = (i_instr[31:26] == OP6_BEQ || i_instr[31:26] == OP6_BNE) ?
                  rd : i_instr[14:10];

    always_comb begin
        rr_op  = ALU_ADD;
        rr_hit = 1'b1;
        case (i_instr[31:15])
            OP17_ADD:  rr_op = ALU_ADD;
            OP17_SUB:  rr_op = ALU_SUB;
            OP17_SLT:  rr_op = ALU_SLT;
            OP17_SLTU: rr_op = ALU_SLTU;
            OP17_AND:  rr_op = ALU_AND;
            OP17_OR:   rr_op = ALU_OR;
            OP17_XOR:  rr_op = ALU_XOR;
            default:   rr_hit = 1'b0;
        endcase
    end

    always_comb begin
        alu_op  = rr_op;
        br_op   = BR_NONE;
        use_imm = 1'b0;
        we_raw  = rr_hit;
        imm     = {{20{i_instr[21]}}, i_instr[21:10]}; // si12
        br_offs = {{14{i_instr[25]}}, i_instr[25:10], 2'b00};
        if (i_instr[31:22] == OP10_ADDI) begin
            alu_op  = ALU_ADD;
            use_imm = 1'b1;
            we_raw  = 1'b1;
        end
        if (i_instr[31:25] == OP7_LU12I) begin
            alu_op  = ALU_LUI;
            use_imm = 1'b1;
            we_raw  = 1'b1;
            imm     = {i_instr[24:5], 12'h000};
        end
        case (i_instr[31:26])
            OP6_BEQ: br_op = BR_EQ;
            OP6_BNE: br_op = BR_NE;
            OP6_B: begin
                br_op   = BR_ALWAYS;
                br_offs = {{4{i_instr[9]}}, i_instr[9:0], i_instr[25:10], 2'b00};
            end
            default: ;
        endcase
    end

    // ID/EX register
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_ex_valid <= 1'b0;
            o_ex_we    <= 1'b0;
            o_ex_br_op <= BR_NONE;
        end else begin
            o_ex_valid <= i_valid & ~i_flush;
            o_ex_we    <= we_raw & (rd != '0);   // r0 writes dropped
            o_ex_br_op <= br_op;
        end
    end

    always_ff @(posedge clk) begin
        o_ex_pc        <= i_pc;
        o_ex_alu_op    <= alu_op;
        o_ex_use_imm   <= use_imm;
        o_ex_imm       <= imm;
        o_ex_rj        <= o_rj;
        o_ex_rk        <= o_rk;
        o_ex_rd        <= rd;
        o_ex_br_target <= i_pc + br_offs;
        o_ex_rdata_j   <= i_rdata_j;
        o_ex_rdata_k   <= i_rdata_k;
    end

endmodule

`default_nettype wire

// File: design/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage import cpu_pkg::*; (
    input  wire logic      clk,
    input  wire logic      i_rst_n,
    input  wire logic      i_ex_valid,
    input  wire word_t     i_ex_pc,
    input  wire alu_op_e   i_ex_alu_op,
    input  wire br_op_e    i_ex_br_op,
    input  wire logic      i_ex_use_imm,
    input  wire word_t     i_ex_imm,
    input  wire reg_addr_t i_ex_rj,
    input  wire reg_addr_t i_ex_rk,
    input  wire reg_addr_t i_ex_rd,
    input  wire logic      i_ex_we,
    input  wire word_t     i_ex_br_target,
    input  wire word_t     i_ex_rdata_j,
    input  wire word_t     i_ex_rdata_k,
    output      logic      o_redirect,
    output      word_t     o_redirect_pc,
    output      word_t     o_wb_pc,
    output      logic      o_wb_we,
    output      reg_addr_t o_wb_rnum,
    output      word_t     o_wb_wdata
);

    word_t src_j;
    word_t src_k;
    word_t op_b;
    word_t alu_res;
    logic  taken;

    // bypass from EX/WB, never matches r0 since its we is dropped in decode
    assign src_j = (o_wb_we && o_wb_rnum == i_ex_rj) ? o_wb_wdata : i_ex_rdata_j;
    assign src_k = (o_wb_we && o_wb_rnum == i_ex_rk) ? o_wb_wdata : i_ex_rdata_k;
    assign op_b  = i_ex_use_imm ? i_ex_imm : src_k;

    always_comb begin
        case (i_ex_alu_op)
            ALU_ADD:  alu_res = src_j + op_b;
            ALU_SUB:  alu_res = src_j - op_b;
            ALU_SLT:  alu_res = {{(XLEN-1){1'b0}}, $signed(src_j) < $signed(op_b)};
            ALU_SLTU: alu_res = {{(XLEN-1){1'b0}}, src_j < op_b};
            ALU_AND:  alu_res = src_j & op_b;
            ALU_OR:   alu_res = src_j | op_b;
            ALU_XOR:  alu_res = src_j ^ op_b;
            ALU_LUI:  alu_res = op_b;
            default:  alu_res = '0;
        endcase
    end

    always_comb begin
        case (i_ex_br_op)
            BR_EQ:     taken = (src_j == src_k);
            BR_NE:     taken = (src_j != src_k);
            BR_ALWAYS: taken = 1'b1;
            default:   taken = 1'b0;
        endcase
    end

    // one cycle only, decode entry gets flushed behind it
    assign o_redirect    = i_ex_valid & taken;
    assign o_redirect_pc = i_ex_br_target;

    // EX/WB register
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_wb_we <= 1'b0;
        end else begin
            o_wb_we <= i_ex_valid & i_ex_we;
        end
    end

    always_ff @(posedge clk) begin
        o_wb_pc    <= i_ex_pc;
        o_wb_rnum  <= i_ex_rd;
        o_wb_wdata <= alu_res;
    end

endmodule

`default_nettype wire

// File: design/cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_top import cpu_pkg::*; #(
    parameter word_t RESET_PC = 32'h1c00_0000
) (
    input  wire logic      clk,
    input  wire logic      i_rst_n,
    output      word_t     o_imem_addr,
    input  wire word_t     i_imem_rdata,
    output      word_t     o_wb_pc,
    output      logic      o_wb_we,
    output      reg_addr_t o_wb_rnum,
    output      word_t     o_wb_wdata
);

    word_t     if_pc;
    logic      if_valid;
    logic      redirect;
    word_t     redirect_pc;

    reg_addr_t rj;
    reg_addr_t rk;
    word_t     rdata_j;
    word_t     rdata_k;

    // ID/EX
    logic      ex_valid;
    word_t     ex_pc;
    alu_op_e   ex_alu_op;
    br_op_e    ex_br_op;
    logic      ex_use_imm;
    word_t     ex_imm;
    reg_addr_t ex_rj;
    reg_addr_t ex_rk;
    reg_addr_t ex_rd;
    logic      ex_we;
    word_t     ex_br_target;
    word_t     ex_rdata_j;
    word_t     ex_rdata_k;

    fetch_stage #(
        .RESET_PC (RESET_PC)
    ) fetch_stage_inst (
        .clk           (clk),
        .i_rst_n       (i_rst_n),
        .i_redirect    (redirect),
        .i_redirect_pc (redirect_pc),
        .o_imem_addr   (o_imem_addr),
        .o_if_pc       (if_pc),
        .o_if_valid    (if_valid)
    );

    decode_stage decode_stage_inst (
        .clk            (clk),
        .i_rst_n        (i_rst_n),
        .i_instr        (i_imem_rdata),
        .i_pc           (if_pc),
        .i_valid        (if_valid),
        .i_flush        (redirect),
        .o_rj           (rj),
        .o_rk           (rk),
        .i_rdata_j      (rdata_j),
        .i_rdata_k      (rdata_k),
        .o_ex_valid     (ex_valid),
        .o_ex_pc        (ex_pc),
        .o_ex_alu_op    (ex_alu_op),
        .o_ex_br_op     (ex_br_op),
        .o_ex_use_imm   (ex_use_imm),
        .o_ex_imm       (ex_imm),
        .o_ex_rj        (ex_rj),
        .o_ex_rk        (ex_rk),
        .o_ex_rd        (ex_rd),
        .o_ex_we        (ex_we),
        .o_ex_br_target (ex_br_target),
        .o_ex_rdata_j   (ex_rdata_j),
        .o_ex_rdata_k   (ex_rdata_k)
    );

    regfile regfile_inst (
        .clk       (clk),
        .i_rst_n   (i_rst_n),
        .i_raddr_a (rj),
        .i_raddr_b (rk),
        .o_rdata_a (rdata_j),
        .o_rdata_b (rdata_k),
        .i_we      (o_wb_we),
        .i_waddr   (o_wb_rnum),
        .i_wdata   (o_wb_wdata)
    );

    execute_stage execute_stage_inst (
        .clk            (clk),
        .i_rst_n        (i_rst_n),
        .i_ex_valid     (ex_valid),
        .i_ex_pc        (ex_pc),
        .i_ex_alu_op    (ex_alu_op),
        .i_ex_br_op     (ex_br_op),
        .i_ex_use_imm   (ex_use_imm),
        .i_ex_imm       (ex_imm),
        .i_ex_rj        (ex_rj),
        .i_ex_rk        (ex_rk),
        .i_ex_rd        (ex_rd),
        .i_ex_we        (ex_we),
        .i_ex_br_target (ex_br_target),
        .i_ex_rdata_j   (ex_rdata_j),
        .i_ex_rdata_k   (ex_rdata_k),
        .o_redirect     (redirect),
        .o_redirect_pc  (redirect_pc),
        .o_wb_pc        (o_wb_pc),
        .o_wb_we        (o_wb_we),
        .o_wb_rnum      (o_wb_rnum),
        .o_wb_wdata     (o_wb_wdata)
    );

endmodule

`default_nettype wire

// File: dv/cpu_ref.svh
`ifndef CPU_REF_SVH
`define CPU_REF_SVH

// fibonacci lfsr with taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        lfsr_state = lfsr_next(lfsr_state); // one step per bit
        v = {v[30:0], lfsr_state[0]};
    end
    return v;
endfunction

function automatic word_t enc_rr(input logic [16:0] op, input reg_addr_t rd,
                                 input reg_addr_t rj, input reg_addr_t rk);
    return {op, rk, rj, rd};
endfunction

function automatic word_t enc_addi(input reg_addr_t rd, input reg_addr_t rj,
                                   input logic [11:0] si12);
    return {OP10_ADDI, si12, rj, rd};
endfunction

function automatic word_t enc_lu12i(input reg_addr_t rd, input logic [19:0] si20);
    return {OP7_LU12I, si20, rd};
endfunction

// offset in words from the branch itself
function automatic word_t enc_bcc(input logic [5:0] op, input reg_addr_t rj,
                                  input reg_addr_t rd, input logic [15:0] offs);
    return {op, offs, rj, rd};
endfunction

function automatic word_t enc_b(input logic [25:0] offs);
    return {OP6_B, offs[15:0], offs[25:16]};
endfunction

// runs prog_q in order and fills the expected trace queues
function automatic void run_reference();
    word_t     regs [NUM_REGS];
    word_t     pc;
    word_t     instr;
    word_t     a;
    word_t     b;
    word_t     res;
    reg_addr_t rd;
    logic      wr;
    int        idx;
    int        offs;
    int        simm;
    for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] = '0;
    end
    pc = RESET_PC;
    for (int step = 0; step < 4096; step++) begin
        idx   = int'((pc - RESET_PC) >> 2);
        instr = prog_q[idx];
        rd    = instr[4:0];
        a     = regs[instr[9:5]];
        b     = regs[instr[14:10]];
        wr    = 1'b1;
        res   = '0;
        if (instr[31:26] == OP6_B) begin
            if ({instr[9:0], instr[25:10]} == 26'd0) begin
                break; // self-loop ends the program
            end
            offs = $signed({instr[9:0], instr[25:10]}); // words
            pc   = pc + 32'(offs * 4);
            continue;
        end
        if (instr[31:26] == OP6_BEQ || instr[31:26] == OP6_BNE) begin
            b = regs[rd];
            if ((a == b) == (instr[31:26] == OP6_BEQ)) begin
                offs = $signed(instr[25:10]);
                pc   = pc + 32'(offs * 4);
            end else begin
                pc = pc + 32'd4;
            end
            continue;
        end
        case (instr[31:15])
            OP17_ADD:  res = a + b;
            OP17_SUB:  res = a - b;
            OP17_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            OP17_SLTU: res = (a < b) ? 32'd1 : 32'd0;
            OP17_AND:  res = a & b;
            OP17_OR:   res = a | b;
            OP17_XOR:  res = a ^ b;
            default: begin
                if (instr[31:22] == OP10_ADDI) begin
                    simm = $signed(instr[21:10]);
                    res  = a + 32'(simm);
                end else if (instr[31:25] == OP7_LU12I) begin
                    res = 32'(instr[24:5]) << 12;
                end else begin
                    wr = 1'b0;
                end
            end
        endcase
        if (wr && rd != 5'd0) begin
            regs[rd] = res;
            exp_pc_q.push_back(pc);
            exp_rnum_q.push_back(rd);
            exp_data_q.push_back(res);
        end
        pc = pc + 32'd4;
    end
endfunction

`endif

// File: dv/tb_cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_top import cpu_pkg::*; ();

    localparam word_t RESET_PC  = 32'h1c00_0000;
    localparam int    MEM_WORDS = 256;
    localparam int    RAND_LEN  = 96;

    logic      clk;
    logic      i_rst_n;
    word_t     o_imem_addr;
    word_t     i_imem_rdata;
    word_t     o_wb_pc;
    logic      o_wb_we;
    reg_addr_t o_wb_rnum;
    word_t     o_wb_wdata;

    word_t       imem [MEM_WORDS];
    word_t       prog_q [$];
    word_t       exp_pc_q [$];
    reg_addr_t   exp_rnum_q [$];
    word_t       exp_data_q [$];
    logic [31:0] lfsr_state;
    int          wb_idx;
    int          value_errs;
    int          trace_errs;
    int          timeout_errs;
    int          cycles;
    int          cycle_limit;
    logic        timed_out;
    logic        running;

    `include "cpu_ref.svh"

    cpu_top #(
        .RESET_PC (RESET_PC)
    ) cpu_top_inst (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .o_imem_addr  (o_imem_addr),
        .i_imem_rdata (i_imem_rdata),
        .o_wb_pc      (o_wb_pc),
        .o_wb_we      (o_wb_we),
        .o_wb_rnum    (o_wb_rnum),
        .o_wb_wdata   (o_wb_wdata)
    );

    always #4 clk = ~clk;

    // opcode 0x3f decodes to nothing, low bits follow the address
    function automatic word_t fill_word(input word_t addr);
        return {6'h3f, addr[31:6] ^ addr[25:0]};
    endfunction

    function automatic word_t imem_read(input word_t addr);
        word_t offs;
        offs = addr - RESET_PC;
        if (offs[1:0] == 2'b00 && offs < 32'(MEM_WORDS * 4)) begin
            return imem[offs[9:2]];
        end
        return fill_word(addr);
    endfunction

    always @(posedge clk) begin
        i_imem_rdata <= imem_read(o_imem_addr); // word for last address
    end

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            value_errs++;
            $display("FAILED %s entry %0d: got %h expected %h", name, wb_idx, got, exp);
        end
    endtask

    task automatic check_reg(input string name, input reg_addr_t got, input reg_addr_t exp);
        if (got !== exp) begin
            value_errs++;
            $display("FAILED %s entry %0d: got %h expected %h", name, wb_idx, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            value_errs++;
            $display("FAILED %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic build_program();
        int        kind;
        int        offs;
        reg_addr_t rd;
        reg_addr_t rj;
        reg_addr_t rk;
        prog_q.delete();
        prog_q.push_back(enc_lu12i(5'd1, 20'h12345));    // first write at RESET_PC
        prog_q.push_back(enc_addi(5'd1, 5'd1, 12'h678));
        prog_q.push_back(enc_addi(5'd2, 5'd0, 12'hffb)); // -5
        prog_q.push_back(enc_lu12i(5'd3, 20'hfffff));
        prog_q.push_back(enc_rr(OP17_ADD, 5'd4, 5'd1, 5'd2));
        prog_q.push_back(enc_rr(OP17_SUB, 5'd5, 5'd4, 5'd1));
        prog_q.push_back(enc_rr(OP17_XOR, 5'd6, 5'd5, 5'd4));
        prog_q.push_back(enc_rr(OP17_OR, 5'd7, 5'd6, 5'd5));
        prog_q.push_back(enc_rr(OP17_AND, 5'd8, 5'd7, 5'd1));
        prog_q.push_back(enc_rr(OP17_SLT, 5'd9, 5'd2, 5'd1));   // -5 < r1 signed
        prog_q.push_back(enc_rr(OP17_SLTU, 5'd10, 5'd2, 5'd1)); // but not unsigned
        prog_q.push_back(enc_addi(5'd0, 5'd1, 12'h007));
        prog_q.push_back(enc_rr(OP17_ADD, 5'd11, 5'd0, 5'd0));
        prog_q.push_back(enc_rr(OP17_OR, 5'd12, 5'd0, 5'd1));
        prog_q.push_back(enc_bcc(OP6_BEQ, 5'd1, 5'd1, 16'd3));  // taken
        prog_q.push_back(enc_addi(5'd13, 5'd0, 12'h111));
        prog_q.push_back(enc_addi(5'd14, 5'd0, 12'h222));
        prog_q.push_back(enc_bcc(OP6_BNE, 5'd1, 5'd1, 16'd3));  // falls through
        prog_q.push_back(enc_addi(5'd13, 5'd0, 12'h333));
        prog_q.push_back(enc_bcc(OP6_BEQ, 5'd2, 5'd1, 16'd2));  // falls through
        prog_q.push_back(enc_b(26'd2));
        prog_q.push_back(enc_addi(5'd14, 5'd0, 12'h444));
        prog_q.push_back(enc_bcc(OP6_BNE, 5'd2, 5'd1, 16'd2));  // taken
        prog_q.push_back(enc_addi(5'd15, 5'd0, 12'h555));
        prog_q.push_back(enc_addi(5'd15, 5'd13, 12'hfff));
        // random body on r0..r7, branches only forward up to the final loop
        for (int i = 0; i < RAND_LEN; i++) begin
            kind = int'(rand_bits(4));
            rd   = 5'(rand_bits(3));
            rj   = 5'(rand_bits(3));
            rk   = 5'(rand_bits(3));
            offs = int'(rand_bits(2)) + 1;
            if (offs > RAND_LEN - i) begin
                offs = RAND_LEN - i;
            end
            case (kind)
                0:       prog_q.push_back(enc_rr(OP17_ADD, rd, rj, rk));
                1:       prog_q.push_back(enc_rr(OP17_SUB, rd, rj, rk));
                2:       prog_q.push_back(enc_rr(OP17_SLT, rd, rj, rk));
                3:       prog_q.push_back(enc_rr(OP17_SLTU, rd, rj, rk));
                4:       prog_q.push_back(enc_rr(OP17_AND, rd, rj, rk));
                5:       prog_q.push_back(enc_rr(OP17_OR, rd, rj, rk));
                6:       prog_q.push_back(enc_rr(OP17_XOR, rd, rj, rk));
                9:       prog_q.push_back(enc_lu12i(rd, 20'(rand_bits(20))));
                10, 11:  prog_q.push_back(enc_bcc(OP6_BEQ, rj, rk, 16'(offs)));
                12, 13:  prog_q.push_back(enc_bcc(OP6_BNE, rj, rk, 16'(offs)));
                14:      prog_q.push_back(enc_b(26'(offs)));
                default: prog_q.push_back(enc_addi(rd, rj, 12'(rand_bits(12))));
            endcase
        end
        prog_q.push_back(enc_b(26'd0)); // self-loop
    endtask

    task automatic load_memory();
        for (int i = 0; i < MEM_WORDS; i++) begin
            imem[i] = (i < prog_q.size()) ? prog_q[i] : fill_word(RESET_PC + 32'(i * 4));
        end
    endtask

    // trace compare, outputs settled by the falling edge
    always @(negedge clk) begin
        if (i_rst_n && o_wb_we) begin
            if (wb_idx < exp_pc_q.size()) begin
                check_word("o_wb_pc", o_wb_pc, exp_pc_q[wb_idx]);
                check_reg("o_wb_rnum", o_wb_rnum, exp_rnum_q[wb_idx]);
                check_word("o_wb_wdata", o_wb_wdata, exp_data_q[wb_idx]);
            end else begin
                trace_errs++;
                $display("trace entry beyond the %0d expected ones, at pc %h",
                         exp_pc_q.size(), o_wb_pc);
            end
            wb_idx++;
        end
    end

    always @(posedge clk) begin
        if (running) begin
            cycles <= cycles + 1;
            if (cycles >= cycle_limit) begin
                timed_out <= 1'b1;
            end
        end
    end

    initial begin
        logic hit_limit;
        clk          = 1'b0;
        i_rst_n      = 1'b0;
        i_imem_rdata = '0;
        lfsr_state   = 32'd95350;
        wb_idx       = 0;
        value_errs   = 0;
        trace_errs   = 0;
        timeout_errs = 0;
        cycles       = 0;
        timed_out    = 1'b0;
        running      = 1'b0;
        build_program();
        load_memory();
        run_reference();
        cycle_limit = prog_q.size() * 4 + 50;

        repeat (2) @(posedge clk);
        @(negedge clk);
        check_word("o_imem_addr", o_imem_addr, RESET_PC);
        check_bit("o_wb_we", o_wb_we, 1'b0);
        @(posedge clk);
        i_rst_n <= 1'b1;
        running <= 1'b1;

        while (wb_idx < exp_pc_q.size() && !timed_out) begin
            @(negedge clk);
        end
        hit_limit = timed_out;
        if (!hit_limit) begin
            repeat (20) @(negedge clk); // stray writes after the last one
        end
        if (hit_limit) begin
            timeout_errs++;
            $display("run stopped by timeout after %0d cycles", cycles);
        end
        if (wb_idx < exp_pc_q.size()) begin
            trace_errs++;
            $display("trace ended after %0d of %0d expected entries",
                     wb_idx, exp_pc_q.size());
        end
        $display("errors: value %0d, trace %0d, timeout %0d",
                 value_errs, trace_errs, timeout_errs);
        if (value_errs + trace_errs + timeout_errs == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
design/cpu_pkg.sv
design/regfile.sv
design/fetch_stage.sv
design/decode_stage.sv
design/execute_stage.sv
design/cpu_top.sv
+incdir+dv
dv/tb_cpu_top.sv

// File: run.sh
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps -j 0 \
    --top-module tb_cpu_top -f sim.f -o tb_cpu_top
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/tb_cpu_top > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qF ">>> FAIL" "$LOG"; then
    exit 1
fi
if ! grep -qF ">>> PASS" "$LOG"; then
    echo "no pass line in $LOG"
    exit 1
fi
exit 0
